/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = uart_tb
FILELIST = src.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* src.f */
uart_pkg.sv
uart_baud_gen.sv
uart_fifo.sv
uart_transmitter.sv
uart_receiver.sv
uart_core.sv
uart_tb.sv

/* uart_baud_gen.sv */
`timescale 1ns/1ps

module uart_baud_gen
	import uart_pkg::*;
(
	input  logic i_CLK,
	input  logic i_RESET,
	output logic o_TICK16,
	output logic o_BIT_TICK
);

	logic [TICK_CNT_W-1:0] clk_cnt;
	logic [SAMPLE_CNT_W-1:0] tick_cnt;

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			clk_cnt <= '0;
			tick_cnt <= '0;
		end
		else
		begin
			if (o_TICK16)
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;

			// Wraps after sixteen ticks.
			if (o_TICK16)
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign o_TICK16 = (clk_cnt == TICK_CNT_W'(CLKS_PER_TICK - 1));

	// Last tick of each bit period.
	assign o_BIT_TICK = o_TICK16 && (tick_cnt == SAMPLE_CNT_W'(OVERSAMPLE - 1));

endmodule

/* uart_core.sv */
`timescale 1ns/1ps

module uart_core
	import uart_pkg::*;
(
	input  logic       i_CLK,
	input  logic       i_RESET,
	input  logic       i_WR,
	input  uart_byte_t i_WR_DATA,
	input  logic       i_RD,
	input  logic       i_RX,
	output logic       o_TX_FULL,
	output logic       o_RX_EMPTY,
	output rx_frame_t  o_RX_FRAME,
	output logic       o_RX_OVERRUN,
	output logic       o_TX,
	output logic       o_TX_BUSY
);

	logic tick16;
	logic bit_tick;
	logic tx_push;
	logic tx_empty;
	logic tx_start;
	uart_byte_t tx_head;
	logic rx_valid;
	logic rx_full;
	logic rx_push;
	logic rx_pop;
	rx_frame_t rx_frame;

	uart_baud_gen baud_gen (
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.o_TICK16(tick16),
		.o_BIT_TICK(bit_tick)
	);

	// Writes into a full FIFO are dropped.
	assign tx_push = i_WR && !o_TX_FULL;

	uart_fifo #(.T(uart_byte_t)) tx_fifo (
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_PUSH(tx_push),
		.i_DATA(i_WR_DATA),
		.i_POP(tx_start),
		.o_DATA(tx_head),
		.o_EMPTY(tx_empty),
		.o_FULL(o_TX_FULL)
	);

	uart_transmitter transmitter (
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_CLK_EN(bit_tick),
		.i_TX_ENABLE(!tx_empty),
		.i_DATA_IN(tx_head),
		.o_TX_BUSY(o_TX_BUSY),
		.o_START(tx_start),
		.o_TX(o_TX)
	);

	uart_receiver receiver (
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_TICK16(tick16),
		.i_RX(i_RX),
		.o_VALID(rx_valid),
		.o_FRAME(rx_frame)
	);

	assign rx_push = rx_valid && !rx_full;
	assign rx_pop = i_RD && !o_RX_EMPTY;

	uart_fifo #(.T(rx_frame_t)) rx_fifo (
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_PUSH(rx_push),
		.i_DATA(rx_frame),
		.i_POP(rx_pop),
		.o_DATA(o_RX_FRAME),
		.o_EMPTY(o_RX_EMPTY),
		.o_FULL(rx_full)
	);

	// Frame lost to a full receive FIFO.
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			o_RX_OVERRUN <= 1'b0;
		else
			o_RX_OVERRUN <= rx_valid && rx_full;
	end

endmodule

/* uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo
	import uart_pkg::*;
#(
	parameter type T = uart_byte_t
)
(
	input  logic i_CLK,
	input  logic i_RESET,
	input  logic i_PUSH,
	input  T     i_DATA,
	input  logic i_POP,
	output T     o_DATA,
	output logic o_EMPTY,
	output logic o_FULL
);

	T mem [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;

	function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge i_CLK)
	begin
		if (i_PUSH)
			mem[wr_ptr] <= i_DATA;
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (i_PUSH)
				wr_ptr <= next_ptr(wr_ptr);
			if (i_POP)
				rd_ptr <= next_ptr(rd_ptr);

			case ({i_PUSH, i_POP})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry is visible without a read.
	assign o_DATA = mem[rd_ptr];
	assign o_EMPTY = (count == '0);
	assign o_FULL = (count == FIFO_CNT_W'(FIFO_DEPTH));

	a_no_push_full: assert property (@(posedge i_CLK) disable iff (i_RESET)
		o_FULL |-> !i_PUSH);

	a_no_pop_empty: assert property (@(posedge i_CLK) disable iff (i_RESET)
		o_EMPTY |-> !i_POP);

endmodule

/* uart_patterns.txt */
# W hh: write byte, R hh f: read and compare byte and framing error flag
# B hh: frame with low stop bit on the testbench line, O: overrun test
W 00
W FF
W A5
R 00 0
R FF 0
R A5 0
W 3C
W 81
W 7E
W 10
W E7
R 3C 0
R 81 0
R 7E 0
R 10 0
R E7 0
B 5A
R 5A 1
O
W C3
R C3 0
B 01
R 01 1

/* uart_pkg.sv */
package uart_pkg;

	// 8N1 frame format.
	localparam int DATA_BITS = 8;

	// Sixteen samples per bit, four clocks per sample.
	localparam int OVERSAMPLE = 16;
	localparam int CLKS_PER_TICK = 4;

	// Entries in each FIFO.
	localparam int FIFO_DEPTH = 4;

	// Derived widths.
	localparam int BIT_CNT_W = $clog2(DATA_BITS);
	localparam int SAMPLE_CNT_W = $clog2(OVERSAMPLE);
	localparam int TICK_CNT_W = $clog2(CLKS_PER_TICK);
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	// Tick index at the middle of a bit.
	localparam int MID_SAMPLE = OVERSAMPLE / 2;

	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// One received byte with its stop bit check.
	typedef struct packed {
		uart_byte_t data;
		logic framing_error;
	} rx_frame_t;

endpackage

/* uart_receiver.sv */
`timescale 1ns/1ps

module uart_receiver
	import uart_pkg::*;
(
	input  logic      i_CLK,
	input  logic      i_RESET,
	input  logic      i_TICK16,
	input  logic      i_RX,
	output logic      o_VALID,
	output rx_frame_t o_FRAME
);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	rx_state_t state;

	logic rx_meta;
	logic rx_sync;
	logic [SAMPLE_CNT_W-1:0] tick_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	uart_byte_t shift_reg;
	logic mid_point;
	logic sample_point;

	// Line idles high.
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= i_RX;
			rx_sync <= rx_meta;
		end
	end

	assign mid_point = i_TICK16 && (tick_cnt == SAMPLE_CNT_W'(MID_SAMPLE - 1));
	assign sample_point = i_TICK16 && (tick_cnt == SAMPLE_CNT_W'(OVERSAMPLE - 1));

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			state <= st_idle;
			tick_cnt <= '0;
			bit_cnt <= '0;
			o_VALID <= 1'b0;
		end
		else
		begin
			o_VALID <= 1'b0;
			case (state)
				st_idle:
				begin
					tick_cnt <= '0;
					bit_cnt <= '0;
					if (!rx_sync)
						state <= st_start;
				end
				st_start:
				begin
					// Half a bit in, the start bit must still be low.
					if (mid_point)
					begin
						tick_cnt <= '0;
						state <= rx_sync ? st_idle : st_data;
					end
					else if (i_TICK16)
						tick_cnt <= tick_cnt + 1'b1;
				end
				st_data:
				begin
					if (sample_point)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1))
							state <= st_stop;
					end
					if (i_TICK16)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
				begin
					if (sample_point)
					begin
						o_VALID <= 1'b1;
						state <= st_idle;
					end
					if (i_TICK16)
						tick_cnt <= tick_cnt + 1'b1;
				end
			endcase
		end
	end

	// LSB arrives first.
	always_ff @(posedge i_CLK)
	begin
		if (state == st_data && sample_point)
			shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};

		if (state == st_stop && sample_point)
		begin
			o_FRAME.data <= shift_reg;
			o_FRAME.framing_error <= ~rx_sync;
		end
	end

	a_valid_pulse: assert property (@(posedge i_CLK) disable iff (i_RESET)
		o_VALID |=> !o_VALID);

endmodule

/* uart_tb.sv */
`timescale 1ns/1ps

module uart_tb
	import uart_pkg::*;
;

	localparam int CLKS_PER_BIT = OVERSAMPLE * CLKS_PER_TICK;
	localparam int FRAME_CLKS = CLKS_PER_BIT * (DATA_BITS + 2);
	localparam int WAIT_LIMIT = 2000;

	logic clk = 1'b0;
	logic reset;
	logic wr;
	uart_byte_t wr_data;
	logic rd;
	logic loop_sel;
	logic tb_line;
	logic rx_line;
	logic tx_full;
	logic rx_empty;
	rx_frame_t rx_frame;
	logic rx_overrun;
	logic tx;
	logic tx_busy;

	int errors = 0;
	int timeouts = 0;
	int n_lines = 0;
	int overrun_pulses = 0;
	int seed = 2;
	logic full_seen = 1'b0;
	logic full_fell = 1'b0;
	logic prev_full = 1'b0;
	logic prev_tx = 1'b1;
	logic frame_active = 1'b0;
	int frame_cnt = 0;

	always #5 clk = ~clk;

	// Loopback or the testbench's own serial line.
	assign rx_line = loop_sel ? tx : tb_line;

	uart_core uut (
		.i_CLK(clk),
		.i_RESET(reset),
		.i_WR(wr),
		.i_WR_DATA(wr_data),
		.i_RD(rd),
		.i_RX(rx_line),
		.o_TX_FULL(tx_full),
		.o_RX_EMPTY(rx_empty),
		.o_RX_FRAME(rx_frame),
		.o_RX_OVERRUN(rx_overrun),
		.o_TX(tx),
		.o_TX_BUSY(tx_busy)
	);

	task automatic check_frame(input string what, input rx_frame_t exp, input rx_frame_t act);
		if (exp !== act)
		begin
			errors++;
			$display("** Error at %0t ns: %s expected data %02h fe %0b, got data %02h fe %0b",
				$time, what, exp.data, exp.framing_error, act.data, act.framing_error);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act)
		begin
			errors++;
			$display("** Error at %0t ns: %s expected %0b, got %0b", $time, what, exp, act);
		end
	endtask

	// Frame shape on o_TX and the status flags.
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (rx_overrun)
				overrun_pulses++;
			if (tx_full && !prev_full)
				full_seen <= 1'b1;
			if (!tx_full && prev_full && full_seen)
				full_fell <= 1'b1;
			prev_full <= tx_full;

			if (!frame_active && prev_tx && !tx)
			begin
				frame_active <= 1'b1;
				frame_cnt <= 1;
				check_flag("busy in start bit", 1'b1, tx_busy);
			end
			else if (frame_active)
			begin
				check_flag("busy during frame", 1'b1, tx_busy);
				if (frame_cnt + 1 <= CLKS_PER_BIT)
					check_flag("start bit level", 1'b0, tx);
				if (frame_cnt + 1 > FRAME_CLKS - CLKS_PER_BIT)
					check_flag("stop bit level", 1'b1, tx);
				if (frame_cnt + 1 == FRAME_CLKS)
					frame_active <= 1'b0;
				frame_cnt <= frame_cnt + 1;
			end
			prev_tx <= tx;
		end
	end

	task automatic write_byte(input uart_byte_t b);
		int n;
		n = 0;
		@(negedge clk);
		while (tx_full && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (tx_full)
		begin
			timeouts++;
			$display("Transmit FIFO stayed full, write of %02h was not made", b);
		end
		else
		begin
			@(posedge clk);
			wr <= 1'b1;
			wr_data <= b;
			@(posedge clk);
			wr <= 1'b0;
		end
	endtask

	task automatic read_frame(input rx_frame_t exp);
		int n;
		n = 0;
		@(negedge clk);
		while (rx_empty && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (rx_empty)
		begin
			timeouts++;
			$display("No frame arrived while waiting for data %02h", exp.data);
		end
		else
		begin
			check_frame("received frame", exp, rx_frame);
			@(posedge clk);
			rd <= 1'b1;
			@(posedge clk);
			rd <= 1'b0;
		end
	endtask

	task automatic drive_bit(input logic b, input int clks);
		@(posedge clk);
		tb_line <= b;
		repeat (clks - 1) @(posedge clk);
	endtask

	task automatic send_serial(input uart_byte_t b, input logic stop);
		drive_bit(1'b0, CLKS_PER_BIT);
		for (int i = 0; i < DATA_BITS; i++)
			drive_bit(b[i], CLKS_PER_BIT);
		// A low stop bit is released early, so the tail fails the start check.
		if (stop)
			drive_bit(1'b1, CLKS_PER_BIT);
		else
		begin
			drive_bit(1'b0, CLKS_PER_BIT * 3 / 4);
			drive_bit(1'b1, CLKS_PER_BIT);
		end
	endtask

	task automatic overrun_test();
		uart_byte_t sent[$];
		uart_byte_t b;
		rx_frame_t exp;
		int start_pulses;
		start_pulses = overrun_pulses;
		@(posedge clk);
		loop_sel <= 1'b0;
		for (int i = 0; i <= FIFO_DEPTH; i++)
		begin
			b = uart_byte_t'($random(seed));
			sent.push_back(b);
			send_serial(b, 1'b1);
		end
		repeat (8) @(posedge clk);
		check_flag("single overrun pulse", 1'b1, (overrun_pulses - start_pulses) == 1);
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			exp.data = sent[i];
			exp.framing_error = 1'b0;
			read_frame(exp);
		end
		@(negedge clk);
		check_flag("receive FIFO empty after overrun", 1'b1, rx_empty);
		@(posedge clk);
		loop_sel <= 1'b1;
	endtask

	initial
	begin
		int fd;
		int code;
		logic [8*80-1:0] line_buf;
		logic [7:0] op;
		logic [7:0] b;
		logic [7:0] f;
		rx_frame_t exp;

		reset = 1'b1;
		wr = 1'b0;
		wr_data = '0;
		rd = 1'b0;
		loop_sel = 1'b1;
		tb_line = 1'b1;

		fd = $fopen("uart_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open uart_patterns.txt");
			$display("FAIL: see errors above");
			$finish;
		end
		else
		begin
			while (!$feof(fd))
			begin
				if ($fgets(line_buf, fd) != 0)
					n_lines++;
			end
			$fclose(fd);

			repeat (4) @(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			check_flag("o_TX after reset", 1'b1, tx);
			check_flag("o_TX_BUSY after reset", 1'b0, tx_busy);
			check_flag("o_RX_EMPTY after reset", 1'b1, rx_empty);
			check_flag("o_RX_OVERRUN after reset", 1'b0, rx_overrun);

			fd = $fopen("uart_patterns.txt", "r");
			code = $fscanf(fd, " %c", op);
			while (code == 1)
			begin
				case (op)
					"W":
					begin
						code = $fscanf(fd, "%h", b);
						write_byte(b);
					end
					"R":
					begin
						code = $fscanf(fd, "%h %h", b, f);
						exp.data = b;
						exp.framing_error = f[0];
						read_frame(exp);
					end
					"B":
					begin
						code = $fscanf(fd, "%h", b);
						@(posedge clk);
						loop_sel <= 1'b0;
						send_serial(b, 1'b0);
						@(posedge clk);
						loop_sel <= 1'b1;
					end
					"O":
						overrun_test();
					default:
						code = $fgets(line_buf, fd);
				endcase
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);

			check_flag("o_TX_FULL rose", 1'b1, full_seen);
			check_flag("o_TX_FULL fell", 1'b1, full_fell);

			$display("Done: %0d errors, %0d timeouts", errors, timeouts);
			if (errors == 0 && timeouts == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

	initial
	begin
		wait (n_lines > 0);
		#(n_lines * WAIT_LIMIT * 10);
		$display("Watchdog expired, the run did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* uart_transmitter.sv */
`timescale 1ns/1ps

module uart_transmitter
	import uart_pkg::*;
(
	input  logic       i_CLK,
	input  logic       i_RESET,
	input  logic       i_CLK_EN,
	input  logic       i_TX_ENABLE,
	input  uart_byte_t i_DATA_IN,
	output logic       o_TX_BUSY,
	output logic       o_START,
	output logic       o_TX
);

	typedef enum logic [1:0] {
		s_idle,
		s_start_tx,
		s_transmit,
		s_stop_tx
	} tx_state_t;

	tx_state_t state;
	tx_state_t next_state;

	logic [BIT_CNT_W-1:0] bit_count;
	uart_byte_t data_reg;

	always_comb
	begin
		case (state)
			s_idle:
				next_state = i_TX_ENABLE ? s_start_tx : s_idle;
			s_start_tx:
				next_state = s_transmit;
			s_transmit:
				next_state = (bit_count == BIT_CNT_W'(DATA_BITS - 1)) ? s_stop_tx : s_transmit;
			default:
				next_state = s_idle;
		endcase
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			state <= s_idle;
			bit_count <= '0;
		end
		else if (i_CLK_EN)
		begin
			state <= next_state;
			// Steps once per bit period.
			if (state == s_transmit)
				bit_count <= bit_count + 1'b1;
			else
				bit_count <= '0;
		end
	end

	// Tracks the FIFO head until a frame begins.
	always_ff @(posedge i_CLK)
	begin
		if (state == s_idle)
			data_reg <= i_DATA_IN;
	end

	assign o_START = (state == s_idle) && i_CLK_EN && i_TX_ENABLE;
	assign o_TX_BUSY = (state != s_idle);

	always_comb
	begin
		case (state)
			s_start_tx:
				o_TX = 1'b0;
			s_transmit:
				o_TX = data_reg[bit_count];
			default:
				o_TX = 1'b1;
		endcase
	end

	// The line only moves on a bit enable.
	a_line_steady: assert property (@(posedge i_CLK) disable iff (i_RESET)
		!i_CLK_EN |=> $stable(o_TX));

	// Every frame begins with a FIFO pop.
	a_start_pop: assert property (@(posedge i_CLK) disable iff (i_RESET)
		$rose(o_TX_BUSY) |-> $past(o_START));

endmodule
